// ==== tb.f ====
+incdir+sim
verilog/dfpPacketPkg.sv
verilog/dfpOpcodePkg.sv
verilog/handshakeStage.sv
verilog/functionProcessor.sv
verilog/memoryAccess.sv
verilog/fpPipeline.sv
sim/tbFpPipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbFpPipeline
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/fpModel.svh ====
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// Reference data memory, written in packet acceptance order
logic [OPERAND_WIDTH-1:0] modelMem [MEM_DEPTH];

function automatic void clearModelMemory();
    modelMem = '{default: '0};
endfunction

// Returns 1 when the packet leaves the pipeline
function automatic logic executePacket(input logic [IN_PACKET_WIDTH-1:0] pkt,
                                       output logic [OUT_PACKET_WIDTH-1:0] result);
    logic [ID_WIDTH-1:0]      id;
    logic [OPCODE_WIDTH-1:0]  op;
    logic                     c;
    logic                     z;
    logic [OPERAND_WIDTH-1:0] dl;
    logic [OPERAND_WIDTH-1:0] dr;
    logic [OPERAND_WIDTH-1:0] data;
    logic [OPERAND_WIDTH:0]   wide;
    logic [COLOR_WIDTH-1:0]   color;
    logic [GEN_WIDTH-1:0]     gen;
    logic [DEST_WIDTH-1:0]    dest;
    logic [LR2_WIDTH-1:0]     lr2;
    logic [1:0]               brCpy;
    logic                     keep;
    {id, op, c, z, dl, dr} = pkt;
    {color, gen, dest, lr2, brCpy} = id;
    data = dl;
    keep = 1'b1;
    wide = {1'b0, dl} + {1'b0, dr};
    case (op)
        OP_ADD:
        begin
            data = wide[OPERAND_WIDTH-1:0];
            c = wide[OPERAND_WIDTH];
        end
        OP_SUB:
        begin
            data = dl - dr;
            c = dl < dr;
        end
        OP_AND:
        begin
            data = dl & dr;
            c = 1'b0;
        end
        OP_OR:
        begin
            data = dl | dr;
            c = 1'b0;
        end
        OP_XOR:
        begin
            data = dl ^ dr;
            c = 1'b0;
        end
        OP_MUL:
            data = dl * dr;
        // Counts past the word width empty it
        OP_SHL:
            data = (dr > 16'd15) ? '0 : dl << dr[3:0];
        OP_SHR:
            data = (dr > 16'd15) ? '0 : dl >> dr[3:0];
        OP_BZ:
        begin
            if (z)
            begin
                dest = dest + 7'd1;
                lr2 = {lr2[0], lr2[1]};
            end
        end
        OP_LDM:
            data = modelMem[wide[MEM_ADDR_WIDTH-1:0]];
        OP_STM:
        begin
            modelMem[dl[MEM_ADDR_WIDTH-1:0]] = dr;
            data = dr;
        end
        OP_ABSORB:
            keep = 1'b0;
        OP_CHGCOL:
            color = dr[COLOR_WIDTH-1:0];
        OP_ADDGEN:
            gen = gen + dr[GEN_WIDTH-1:0];
        OP_DECGEN:
            gen = gen - 8'd1;
        default:
            keep = 1'b1;
    endcase
    if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_SHL, OP_SHR})
        z = (data == '0);
    result = {color, gen, dest, lr2, brCpy, c, z, data};
    return keep;
endfunction

`endif

// ==== sim/tbFpPipeline.sv ====
`timescale 1ns/10ps

module tbFpPipeline;

    import dfpPacketPkg::*;
    import dfpOpcodePkg::*;

    localparam int NUM_PACKETS = 400;
    localparam int STALL_LIMIT = 200;
    localparam int RUN_LIMIT = 20000;

    logic                        CP;
    logic                        MR;
    logic                        sendIn;
    logic                        ackOut;
    logic [IN_PACKET_WIDTH-1:0]  packetIn;
    logic                        sendOut;
    logic                        ackIn;
    logic [OUT_PACKET_WIDTH-1:0] packetOut;

    logic [15:0]                 lfsrState;
    logic [OPCODE_WIDTH-1:0]     opcodeList [15];
    logic [OUT_PACKET_WIDTH-1:0] expectedQueue [$];
    string                       nameQueue [$];
    int                          errorCount;
    int                          sentCount;
    int                          outCount;
    int                          expectedCount;
    int                          stallCycles;

    // Expected occupancy of the two pipeline slots
    logic                        fpSlotFull;
    logic                        fpSlotAbsorb;
    logic                        memSlotFull;

    `include "fpModel.svh"

    fpPipeline fpPipeline_i (
        .CP(CP),
        .MR(MR),
        .sendIn(sendIn),
        .ackOut(ackOut),
        .packetIn(packetIn),
        .sendOut(sendOut),
        .ackIn(ackIn),
        .packetOut(packetOut)
    );

    initial
    begin
        CP = 1'b0;
        forever #10 CP = ~CP;
    end

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < count; i++)
        begin
            lfsrState = stepLfsr(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic logic [IN_PACKET_WIDTH-1:0] randomPacket();
        logic [OPCODE_WIDTH-1:0]  op;
        logic [3:0]               pick;
        logic [ID_WIDTH-1:0]      id;
        logic [1:0]               flags;
        logic [OPERAND_WIDTH-1:0] dl;
        logic [OPERAND_WIDTH-1:0] dr;
        pick = 4'(randomBits(4) % 15);
        op = opcodeList[pick];
        id = ID_WIDTH'(randomBits(ID_WIDTH));
        flags = 2'(randomBits(2));
        dl = OPERAND_WIDTH'(randomBits(OPERAND_WIDTH));
        dr = OPERAND_WIDTH'(randomBits(OPERAND_WIDTH));
        // Short shift counts and few addresses so loads hit stored words
        if (op == OP_SHL || op == OP_SHR)
            dr = OPERAND_WIDTH'(randomBits(5));
        if (op == OP_STM || op == OP_LDM)
            dl = OPERAND_WIDTH'(randomBits(3));
        if (op == OP_LDM)
            dr = OPERAND_WIDTH'(randomBits(1));
        return {id, op, flags, dl, dr};
    endfunction

    task automatic checkValue(input string testName,
                              input logic [OUT_PACKET_WIDTH-1:0] expected,
                              input logic [OUT_PACKET_WIDTH-1:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("** Error %s: expected %h, actual %h at %0t",
                     testName, expected, actual, $time);
        end
    endtask

    // Links sampled at the rising edge and driven at the falling edge
    task automatic runCycle();
        logic [OUT_PACKET_WIDTH-1:0] expected;
        logic                        accepted;
        logic                        keep;
        logic                        expectedAck;
        logic                        toMemStage;
        logic [OPCODE_WIDTH-1:0]     acceptedOp;
        @(posedge CP);
        expectedAck = !fpSlotFull || fpSlotAbsorb || !memSlotFull || ackIn;
        checkValue("sendOut handshake", OUT_PACKET_WIDTH'(memSlotFull),
                   OUT_PACKET_WIDTH'(sendOut));
        checkValue("ackOut handshake", OUT_PACKET_WIDTH'(expectedAck),
                   OUT_PACKET_WIDTH'(ackOut));
        if (sendOut && ackIn)
        begin
            outCount++;
            if (expectedQueue.size() == 0)
            begin
                errorCount++;
                $display("Output packet %h arrived while no packet was expected", packetOut);
            end
            else
                checkValue(nameQueue.pop_front(), expectedQueue.pop_front(), packetOut);
        end
        accepted = sendIn && ackOut;
        acceptedOp = packetIn[IN_PACKET_WIDTH-ID_WIDTH-1 -: OPCODE_WIDTH];
        // Slot occupancy after this edge
        toMemStage = fpSlotFull && !fpSlotAbsorb && (!memSlotFull || ackIn);
        if (toMemStage)
            memSlotFull = 1'b1;
        else if (ackIn)
            memSlotFull = 1'b0;
        if (accepted)
        begin
            fpSlotFull = 1'b1;
            fpSlotAbsorb = (acceptedOp == OP_ABSORB);
        end
        else if (fpSlotAbsorb || toMemStage)
            fpSlotFull = 1'b0;
        if (accepted)
        begin
            keep = executePacket(packetIn, expected);
            if (keep)
            begin
                expectedQueue.push_back(expected);
                nameQueue.push_back($sformatf("packet %0d opcode %h", sentCount,
                    acceptedOp));
                expectedCount++;
            end
            sentCount++;
            stallCycles = 0;
        end
        else if (sendIn)
            stallCycles++;
        @(negedge CP);
        ackIn = randomBits(2) != 0;
        if (!sendIn || accepted)
        begin
            sendIn = (sentCount < NUM_PACKETS) && (randomBits(2) != 0);
            if (sendIn)
                packetIn = randomPacket();
        end
    endtask

    initial
    begin
        int  cycle;
        logic timedOut;
        MR = 1'b1;
        sendIn = 1'b0;
        ackIn = 1'b0;
        packetIn = '0;
        lfsrState = 16'd38;
        errorCount = 0;
        sentCount = 0;
        outCount = 0;
        expectedCount = 0;
        stallCycles = 0;
        fpSlotFull = 1'b0;
        fpSlotAbsorb = 1'b0;
        memSlotFull = 1'b0;
        cycle = 0;
        timedOut = 1'b0;
        opcodeList = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_SHL, OP_SHR,
                       OP_BZ, OP_LDM, OP_STM, OP_ABSORB, OP_CHGCOL, OP_ADDGEN, OP_DECGEN};
        clearModelMemory();
        repeat (2) @(posedge CP);
        @(negedge CP);
        MR = 1'b0;

        while (!timedOut && (sentCount < NUM_PACKETS || expectedQueue.size() != 0))
        begin
            runCycle();
            cycle++;
            if (stallCycles > STALL_LIMIT)
            begin
                $display("Input packet was not accepted within %0d cycles", STALL_LIMIT);
                errorCount++;
                timedOut = 1'b1;
            end
            else if (cycle > RUN_LIMIT)
            begin
                $display("Run did not finish within %0d cycles, %0d packets still expected",
                         RUN_LIMIT, expectedQueue.size());
                errorCount++;
                timedOut = 1'b1;
            end
        end
        // Quiet window to catch stray output packets
        if (!timedOut)
            repeat (10) runCycle();
        checkValue("output count", OUT_PACKET_WIDTH'(expectedCount),
                   OUT_PACKET_WIDTH'(outCount));

        $display("Closing: %0d errors, %0d packets in, %0d packets out",
                 errorCount, sentCount, outCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog/fpPipeline.sv ====
`timescale 1ns/10ps

module fpPipeline (
    input  logic                                   CP,
    input  logic                                   MR,
    input  logic                                   sendIn,
    output logic                                   ackOut,
    input  logic [dfpPacketPkg::IN_PACKET_WIDTH-1:0]  packetIn,
    output logic                                   sendOut,
    input  logic                                   ackIn,
    output logic [dfpPacketPkg::OUT_PACKET_WIDTH-1:0] packetOut
);

    import dfpPacketPkg::*;

    // Function processor to memory access link
    logic                        fpSend;
    logic                        fpAck;
    logic [OUT_PACKET_WIDTH-1:0] fpPacket;
    logic                        writeEn;
    logic                        loadFlg;
    logic [MEM_ADDR_WIDTH-1:0]   storeAddr;

    functionProcessor functionProcessor_i (
        .CP(CP),
        .MR(MR),
        .sendIn(sendIn),
        .ackOut(ackOut),
        .packetIn(packetIn),
        .sendOut(fpSend),
        .ackIn(fpAck),
        .packetOut(fpPacket),
        .writeEn(writeEn),
        .loadFlg(loadFlg),
        .storeAddr(storeAddr)
    );

    memoryAccess memoryAccess_i (
        .CP(CP),
        .MR(MR),
        .sendIn(fpSend),
        .ackOut(fpAck),
        .packetIn(fpPacket),
        .writeEn(writeEn),
        .loadFlg(loadFlg),
        .storeAddr(storeAddr),
        .sendOut(sendOut),
        .ackIn(ackIn),
        .packetOut(packetOut)
    );

endmodule

// ==== verilog/memoryAccess.sv ====
`timescale 1ns/10ps

module memoryAccess (
    input  logic                                   CP,
    input  logic                                   MR,
    input  logic                                   sendIn,
    output logic                                   ackOut,
    input  logic [dfpPacketPkg::OUT_PACKET_WIDTH-1:0] packetIn,
    input  logic                                   writeEn,
    input  logic                                   loadFlg,
    input  logic [dfpPacketPkg::MEM_ADDR_WIDTH-1:0]   storeAddr,
    output logic                                   sendOut,
    input  logic                                   ackIn,
    output logic [dfpPacketPkg::OUT_PACKET_WIDTH-1:0] packetOut
);

    import dfpPacketPkg::*;

    logic [OPERAND_WIDTH-1:0]    dataMem [MEM_DEPTH];
    logic [MEM_ADDR_WIDTH-1:0]   loadAddr;
    logic [OUT_PACKET_WIDTH-1:0] stagedPacket;
    logic                        accept;

    assign accept = sendIn && ackOut;
    assign loadAddr = packetIn[MEM_ADDR_WIDTH-1:0];

    // Load replaces only the data field
    assign stagedPacket = loadFlg ?
        {packetIn[OUT_PACKET_WIDTH-1:OPERAND_WIDTH], dataMem[loadAddr]} : packetIn;

    always_ff @(posedge CP or posedge MR)
    begin
        if (MR)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
                dataMem[i] <= '0;
        end
        else if (accept && writeEn)
            dataMem[storeAddr] <= packetIn[OPERAND_WIDTH-1:0];
    end

    // Result packet register
    handshakeStage #(
        .WIDTH(OUT_PACKET_WIDTH)
    ) resultStage (
        .CP(CP),
        .MR(MR),
        .sendIn(sendIn),
        .ackOut(ackOut),
        .dataIn(stagedPacket),
        .sendOut(sendOut),
        .ackIn(ackIn),
        .dataOut(packetOut)
    );

    assert property (@(posedge CP) disable iff (MR)
        !(writeEn && loadFlg));

endmodule

// ==== verilog/functionProcessor.sv ====
`timescale 1ns/10ps

module functionProcessor (
    input  logic                                   CP,
    input  logic                                   MR,
    input  logic                                   sendIn,
    output logic                                   ackOut,
    input  logic [dfpPacketPkg::IN_PACKET_WIDTH-1:0]  packetIn,
    output logic                                   sendOut,
    input  logic                                   ackIn,
    output logic [dfpPacketPkg::OUT_PACKET_WIDTH-1:0] packetOut,
    output logic                                   writeEn,
    output logic                                   loadFlg,
    output logic [dfpPacketPkg::MEM_ADDR_WIDTH-1:0]   storeAddr
);

    import dfpPacketPkg::*;
    import dfpOpcodePkg::*;

    logic                       slotFull;
    logic                       slotAck;
    logic [IN_PACKET_WIDTH-1:0] slotData;

    logic [COLOR_WIDTH-1:0]   color;
    logic [GEN_WIDTH-1:0]     gen;
    logic [DEST_WIDTH-1:0]    dest;
    logic [LR2_WIDTH-1:0]     lr2;
    logic                     br;
    logic                     cpy;
    logic [OPCODE_WIDTH-1:0]  opcode;
    logic                     cIn;
    logic                     zIn;
    logic [OPERAND_WIDTH-1:0] dataL;
    logic [OPERAND_WIDTH-1:0] dataR;

    logic [COLOR_WIDTH-1:0]   newColor;
    logic [GEN_WIDTH-1:0]     newGen;
    logic [DEST_WIDTH-1:0]    newDest;
    logic [LR2_WIDTH-1:0]     newLr2;
    logic                     newC;
    logic                     newZ;
    logic [OPERAND_WIDTH-1:0] newData;
    logic [OPERAND_WIDTH:0]   sum;
    logic                     aluOp;
    logic                     storeOp;
    logic                     loadOp;
    logic                     absorbOp;
    logic                     dropItem;

    // Operand packet register
    handshakeStage #(
        .WIDTH(IN_PACKET_WIDTH)
    ) operandStage (
        .CP(CP),
        .MR(MR),
        .sendIn(sendIn),
        .ackOut(ackOut),
        .dataIn(packetIn),
        .sendOut(slotFull),
        .ackIn(slotAck),
        .dataOut(slotData)
    );

    assign {color, gen, dest, lr2, br, cpy, opcode, cIn, zIn, dataL, dataR} = slotData;

    always_comb
    begin
        sum = {1'b0, dataL} + {1'b0, dataR};
        newColor = color;
        newGen = gen;
        newDest = dest;
        newLr2 = lr2;
        newC = cIn;
        newZ = zIn;
        newData = dataL;
        aluOp = 1'b0;
        storeOp = 1'b0;
        loadOp = 1'b0;
        absorbOp = 1'b0;
        case (opcode)
            OP_ADD:
            begin
                newData = sum[OPERAND_WIDTH-1:0];
                newC = sum[OPERAND_WIDTH];
                aluOp = 1'b1;
            end
            OP_SUB:
            begin
                newData = dataL - dataR;
                newC = dataL < dataR;
                aluOp = 1'b1;
            end
            OP_AND:
            begin
                newData = dataL & dataR;
                newC = 1'b0;
                aluOp = 1'b1;
            end
            OP_OR:
            begin
                newData = dataL | dataR;
                newC = 1'b0;
                aluOp = 1'b1;
            end
            OP_XOR:
            begin
                newData = dataL ^ dataR;
                newC = 1'b0;
                aluOp = 1'b1;
            end
            OP_MUL:
            begin
                newData = dataL * dataR;
                aluOp = 1'b1;
            end
            OP_SHL:
            begin
                newData = dataL << dataR;
                aluOp = 1'b1;
            end
            OP_SHR:
            begin
                newData = dataL >> dataR;
                aluOp = 1'b1;
            end
            OP_BZ:
            begin
                // Taken branch steers to the next node, swapped port
                if (zIn)
                begin
                    newDest = dest + DEST_WIDTH'(1);
                    newLr2 = {lr2[0], lr2[1]};
                end
            end
            OP_LDM:
            begin
                newData = sum[OPERAND_WIDTH-1:0];
                loadOp = 1'b1;
            end
            OP_STM:
            begin
                newData = dataR;
                storeOp = 1'b1;
            end
            OP_ABSORB:
                absorbOp = 1'b1;
            OP_CHGCOL:
                newColor = dataR[COLOR_WIDTH-1:0];
            OP_ADDGEN:
                newGen = gen + dataR[GEN_WIDTH-1:0];
            OP_DECGEN:
                newGen = gen - GEN_WIDTH'(1);
            default:
            begin
                newData = dataL;
            end
        endcase
        if (aluOp)
            newZ = (newData == '0);
    end

    // Absorbed packets leave the slot without being offered
    assign dropItem = slotFull && absorbOp;
    assign slotAck = ackIn || dropItem;
    assign sendOut = slotFull && !absorbOp;

    assign packetOut = {newColor, newGen, newDest, newLr2, br, cpy, newC, newZ, newData};
    assign writeEn = slotFull && storeOp;
    assign loadFlg = slotFull && loadOp;
    assign storeAddr = dataL[MEM_ADDR_WIDTH-1:0];

    assert property (@(posedge CP) disable iff (MR)
        slotFull |-> isImplemented(opcode));

endmodule

// ==== verilog/handshakeStage.sv ====
`timescale 1ns/10ps

module handshakeStage #(
    parameter int WIDTH = 62
) (
    input  logic             CP,
    input  logic             MR,
    input  logic             sendIn,
    output logic             ackOut,
    input  logic [WIDTH-1:0] dataIn,
    output logic             sendOut,
    input  logic             ackIn,
    output logic [WIDTH-1:0] dataOut
);

    logic             full;
    logic [WIDTH-1:0] slotData;
    logic             loadSlot;

    // Free slot, or the item leaves this cycle
    assign ackOut = !full || ackIn;
    assign loadSlot = sendIn && ackOut;

    assign sendOut = full;
    assign dataOut = slotData;

    always_ff @(posedge CP or posedge MR)
    begin
        if (MR)
            full <= 1'b0;
        else if (loadSlot)
            full <= 1'b1;
        else if (ackIn)
            full <= 1'b0;
    end

    always_ff @(posedge CP)
    begin
        if (loadSlot)
            slotData <= dataIn;
    end

    // Offered item held until taken
    assert property (@(posedge CP) disable iff (MR)
        sendOut && !ackIn |=> $stable(dataOut));

endmodule

// ==== verilog/dfpOpcodePkg.sv ====
package dfpOpcodePkg;

    localparam int OPCODE_WIDTH = 6;

    // Arithmetic, logic and shift
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 6'h00;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADDC = 6'h01;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 6'h02;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUBC = 6'h03;
    localparam logic [OPCODE_WIDTH-1:0] OP_AND = 6'h04;
    localparam logic [OPCODE_WIDTH-1:0] OP_OR = 6'h05;
    localparam logic [OPCODE_WIDTH-1:0] OP_XOR = 6'h06;
    localparam logic [OPCODE_WIDTH-1:0] OP_MUL = 6'h07;
    localparam logic [OPCODE_WIDTH-1:0] OP_SHL = 6'h08;
    localparam logic [OPCODE_WIDTH-1:0] OP_SHR = 6'h09;
    localparam logic [OPCODE_WIDTH-1:0] OP_ROL = 6'h0a;
    localparam logic [OPCODE_WIDTH-1:0] OP_ROR = 6'h0b;

    // Conditional branch
    localparam logic [OPCODE_WIDTH-1:0] OP_BZ = 6'h10;
    localparam logic [OPCODE_WIDTH-1:0] OP_BNZ = 6'h11;
    localparam logic [OPCODE_WIDTH-1:0] OP_BC = 6'h12;
    localparam logic [OPCODE_WIDTH-1:0] OP_BNC = 6'h13;
    localparam logic [OPCODE_WIDTH-1:0] OP_BZL = 6'h14;
    localparam logic [OPCODE_WIDTH-1:0] OP_BNZL = 6'h15;

    // Memory, packet removal, identifier change
    localparam logic [OPCODE_WIDTH-1:0] OP_LDM = 6'h18;
    localparam logic [OPCODE_WIDTH-1:0] OP_STM = 6'h19;
    localparam logic [OPCODE_WIDTH-1:0] OP_ABSORB = 6'h20;
    localparam logic [OPCODE_WIDTH-1:0] OP_CHGCOL = 6'h28;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADDGEN = 6'h29;
    localparam logic [OPCODE_WIDTH-1:0] OP_DECGEN = 6'h2a;

    function automatic logic isImplemented(input logic [OPCODE_WIDTH-1:0] op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_SHL, OP_SHR,
            OP_BZ, OP_LDM, OP_STM, OP_ABSORB, OP_CHGCOL, OP_ADDGEN, OP_DECGEN:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage

// ==== verilog/dfpPacketPkg.sv ====
package dfpPacketPkg;

    // Identifier fields, top to bottom
    localparam int COLOR_WIDTH = 3;
    localparam int GEN_WIDTH = 8;
    localparam int DEST_WIDTH = 7;
    localparam int LR2_WIDTH = 2;

    localparam int OPERAND_WIDTH = 16;

    // color, gen, dest, LR2, BR, CPY
    localparam int ID_WIDTH = COLOR_WIDTH + GEN_WIDTH + DEST_WIDTH + LR2_WIDTH + 2;

    // Identifier, opcode, C, Z, DataL, DataR
    localparam int IN_PACKET_WIDTH = ID_WIDTH + 6 + 2 + 2 * OPERAND_WIDTH;

    // Identifier, C, Z, result data
    localparam int OUT_PACKET_WIDTH = ID_WIDTH + 2 + OPERAND_WIDTH;

    localparam int MEM_DEPTH = 16;
    localparam int MEM_ADDR_WIDTH = 4;

endpackage
